// File: src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 256;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [TAG_W-1:0]                 tag_t;
    typedef logic [INDEX_W-1:0]               index_t;
    // Word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]      way_t;
    typedef logic [NUM_WAYS-1:0]              way_mask_t;

    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    // Shift the line down to the requested word
    function automatic line_t align_line(line_t ln, logic [1:0] word_sel);
        return ln >> (word_sel * WORD_W);
    endfunction

endpackage

`default_nettype wire

// File: src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    import cache_geom_pkg::*;

    // Level, held until rd_rdy
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_req_t;

    // One-cycle strobe carrying the whole line
    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_ret_t;

endpackage

`default_nettype wire

// File: src/way_ram.sv
`timescale 1ns/1ps
`default_nettype none

module way_ram
    import cache_geom_pkg::*;
#(
    parameter type payload_t = tag_t
) (
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  index_t   index,
    input  payload_t din,
    output payload_t dout
);

    payload_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[index] <= din;
            end else begin
                dout <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/valid_array.sv
`timescale 1ns/1ps
`default_nettype none

module valid_array
    import cache_geom_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      fill,
    input  way_t      fill_way,
    input  index_t    fill_index,
    input  index_t    rd_index,
    output way_mask_t valid_bits
);

    way_mask_t vbits [NUM_SETS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                vbits[s] <= '0;
            end
        end else if (fill) begin
            vbits[fill_index][fill_way] <= 1'b1;
        end
    end

    // Read at the buffered index during lookup
    assign valid_bits = vbits[rd_index];

endmodule

`default_nettype wire

// File: src/plru_table.sv
`timescale 1ns/1ps
`default_nettype none

module plru_table
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   touch,
    input  way_t   touch_way,
    input  index_t index,
    output way_t   victim
);

    way_mask_t mru [NUM_SETS];
    way_mask_t cur_bits;
    way_mask_t way_bit;
    way_mask_t next_bits;

    assign cur_bits = mru[index];
    assign way_bit  = way_mask_t'(1) << touch_way;

    always_comb begin
        // Other three already set so a new round starts
        if ((cur_bits | way_bit) == '1) begin
            next_bits = way_bit;
        end else begin
            next_bits = cur_bits | way_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mru[s] <= '0;
            end
        end else if (touch) begin
            mru[index] <= next_bits;
        end
    end

    // Lowest way not recently used
    always_comb begin
        victim = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!cur_bits[w]) begin
                victim = way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/hit_select.sv
`timescale 1ns/1ps
`default_nettype none

module hit_select
    import cache_geom_pkg::*;
(
    input  tag_t       tags [NUM_WAYS],
    input  line_t      lines [NUM_WAYS],
    input  way_mask_t  valid_bits,
    input  tag_t       req_tag,
    input  logic [1:0] word_sel,
    output way_mask_t  hit_mask,
    output line_t      hit_line
);

    line_t sel_line;

    always_comb begin
        sel_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_mask[w] = valid_bits[w] && (tags[w] == req_tag);
            // At most one way hits
            if (hit_mask[w]) begin
                sel_line = sel_line | lines[w];
            end
        end
    end

    assign hit_line = align_line(sel_line, word_sel);

endmodule

`default_nettype wire

// File: src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  cache_addr_t addr,
    output logic        addr_ok,
    output logic        data_ok,
    output line_t       rdata,
    input  way_mask_t   hit_mask,
    input  line_t       hit_line,
    input  way_t        victim,
    input  logic        rd_rdy,
    input  mem_ret_t    mem_ret,
    output mem_req_t    mem_req,
    output logic        ram_en,
    output logic        fill,
    output way_t        fill_way,
    output index_t      ram_index,
    output cache_addr_t req_addr,
    output logic        touch,
    output way_t        touch_way
);

    typedef enum logic [3:0] {
        IDLE    = 4'b0001,
        LOOKUP  = 4'b0010,
        REPLACE = 4'b0100,
        REFILL  = 4'b1000
    } state_t;

    state_t      state;
    state_t      next_state;
    cache_addr_t rb;
    way_t        rp_way;
    way_t        hit_way;
    logic        hit;
    logic        accept;

    assign hit     = |hit_mask;
    assign addr_ok = valid && (state == IDLE || (state == LOOKUP && hit));
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    next_state = REPLACE;
                end else if (!accept) begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (mem_ret.valid) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rb <= addr;
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && !hit) begin
            rp_way <= victim;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign fill      = (state == REFILL) && mem_ret.valid;
    assign fill_way  = rp_way;
    assign ram_en    = accept || fill;
    assign ram_index = accept ? addr.index : rb.index;
    assign req_addr  = rb;

    // Replace way marked used for every cycle of REPLACE
    assign touch     = (state == LOOKUP && hit) || (state == REPLACE);
    assign touch_way = (state == LOOKUP) ? hit_way : rp_way;

    assign data_ok = (state == LOOKUP && hit) || fill;
    assign rdata   = (state == LOOKUP) ? hit_line
                                       : align_line(mem_ret.data, rb.offset[3:2]);

    assign mem_req = '{req: (state == REPLACE), addr: {rb.tag, rb.index, {OFFSET_W{1'b0}}}};

endmodule

`default_nettype wire

// File: src/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  cache_addr_t addr,
    output logic        addr_ok,
    output logic        data_ok,
    output line_t       rdata,
    output mem_req_t    mem_req,
    input  logic        rd_rdy,
    input  mem_ret_t    mem_ret
);

    tag_t        tag_dout [NUM_WAYS];
    line_t       line_dout [NUM_WAYS];
    way_mask_t   valid_bits;
    way_mask_t   hit_mask;
    line_t       hit_line;
    way_t        victim;
    logic        ram_en;
    logic        fill;
    way_t        fill_way;
    index_t      ram_index;
    cache_addr_t req_addr;
    logic        touch;
    way_t        touch_way;

    cache_ctrl ctrl_i (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .hit_mask  (hit_mask),
        .hit_line  (hit_line),
        .victim    (victim),
        .rd_rdy    (rd_rdy),
        .mem_ret   (mem_ret),
        .mem_req   (mem_req),
        .ram_en    (ram_en),
        .fill      (fill),
        .fill_way  (fill_way),
        .ram_index (ram_index),
        .req_addr  (req_addr),
        .touch     (touch),
        .touch_way (touch_way)
    );

    // Tag and line RAMs per way, written only for the victim
    generate
        for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
            way_ram #(.payload_t(tag_t)) tag_ram_i (
                .clk   (clk),
                .en    (ram_en),
                .we    (fill && (fill_way == way_t'(w))),
                .index (ram_index),
                .din   (req_addr.tag),
                .dout  (tag_dout[w])
            );
            way_ram #(.payload_t(line_t)) data_ram_i (
                .clk   (clk),
                .en    (ram_en),
                .we    (fill && (fill_way == way_t'(w))),
                .index (ram_index),
                .din   (mem_ret.data),
                .dout  (line_dout[w])
            );
        end
    endgenerate

    valid_array valid_i (
        .clk        (clk),
        .resetn     (resetn),
        .fill       (fill),
        .fill_way   (fill_way),
        .fill_index (req_addr.index),
        .rd_index   (req_addr.index),
        .valid_bits (valid_bits)
    );

    plru_table plru_i (
        .clk       (clk),
        .resetn    (resetn),
        .touch     (touch),
        .touch_way (touch_way),
        .index     (req_addr.index),
        .victim    (victim)
    );

    hit_select hit_i (
        .tags       (tag_dout),
        .lines      (line_dout),
        .valid_bits (valid_bits),
        .req_tag    (req_addr.tag),
        .word_sel   (req_addr.offset[3:2]),
        .hit_mask   (hit_mask),
        .hit_line   (hit_line)
    );

endmodule

`default_nettype wire

// File: test/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int WAIT_LIMIT = 40;

    logic        clk;
    logic        resetn;
    logic        valid;
    cache_addr_t addr;
    logic        addr_ok;
    logic        data_ok;
    line_t       rdata;
    mem_req_t    mem_req;
    logic        rd_rdy;
    mem_ret_t    mem_ret;

    integer      seed;
    int          errors;
    int          timeouts;
    bit          timed_out;
    logic [31:0] vec_addr [$];
    bit          vec_miss [$];
    bit          vec_burst [$];
    tag_t        model_tag [NUM_SETS][NUM_WAYS];
    bit          model_valid [NUM_SETS][NUM_WAYS];
    way_mask_t   model_mru [NUM_SETS];

    icache icache_i (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .addr    (addr),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata),
        .mem_req (mem_req),
        .rd_rdy  (rd_rdy),
        .mem_ret (mem_ret)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory contents follow the line address
    function automatic line_t line_for(logic [31:0] a);
        line_t       ln;
        logic [31:0] base;
        base = {a[31:4], 4'b0000};
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            ln[k*WORD_W +: WORD_W] = (base + 32'(4 * k)) ^ 32'h5A5A_0000;
        end
        return ln;
    endfunction

    function automatic line_t expected_rdata(logic [31:0] a);
        int shift;
        shift = WORD_W * int'(a[3:2]);
        return line_for(a) >> shift;
    endfunction

    function automatic void mark_used(index_t idx, int way);
        way_mask_t bits;
        bits = model_mru[idx];
        bits[way] = 1'b1;
        if (bits == 4'b1111) begin
            bits = '0;
            bits[way] = 1'b1;
        end
        model_mru[idx] = bits;
    endfunction

    // Returns 1 on a predicted miss and updates the model
    function automatic bit predict_access(logic [31:0] a);
        cache_addr_t ca;
        int          hit_way;
        int          victim;
        bit          found;
        ca = cache_addr_t'(a);
        hit_way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[ca.index][w] && model_tag[ca.index][w] == ca.tag) begin
                hit_way = w;
            end
        end
        if (hit_way >= 0) begin
            mark_used(ca.index, hit_way);
            return 1'b0;
        end
        victim = 0;
        found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !model_mru[ca.index][w]) begin
                victim = w;
                found = 1'b1;
            end
        end
        mark_used(ca.index, victim);
        model_tag[ca.index][victim] = ca.tag;
        model_valid[ca.index][victim] = 1'b1;
        return 1'b1;
    endfunction

    task automatic load_vectors();
        logic [8*100-1:0] text;
        logic [31:0]      a;
        int               fd;
        int               miss;
        int               burst;
        int               code;
        fd = $fopen("test/icache_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = '0;
            code = $fgets(text, fd);
            // Comment and blank lines do not parse
            if (code != 0 && $sscanf(text, "%h %d %d", a, miss, burst) == 3) begin
                vec_addr.push_back(a);
                vec_miss.push_back(miss != 0);
                vec_burst.push_back(burst != 0);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_accept(logic [31:0] a, output bit ok);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!addr_ok && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        ok = addr_ok;
        if (!ok) begin
            $display("timeout: fetch %h was never accepted", a);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic play_one(int i);
        logic [31:0] a;
        logic [31:0] first_addr;
        bit          model_miss;
        bit          req_seen;
        bit          mem_taken;
        bit          ok;
        int          cnt;
        a = vec_addr[i];
        model_miss = predict_access(a);
        assert (model_miss == vec_miss[i]) else begin
            errors++;
            $display("reference model disagrees with the vector flag at %h", a);
        end
        req_seen = 1'b0;
        mem_taken = 1'b0;
        first_addr = '0;
        valid = 1'b1;
        addr = cache_addr_t'(a);
        wait_accept(a, ok);
        if (!ok) begin
            return;
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!data_ok && cnt < WAIT_LIMIT) begin
            if (!mem_taken) begin
                if (req_seen) begin
                    assert (mem_req.req) else begin
                        errors++;
                        $display("error mem_req.req at %h: expected 1 got %h", a, mem_req.req);
                    end
                end
                if (mem_req.req && !req_seen) begin
                    req_seen = 1'b1;
                    first_addr = mem_req.addr;
                    assert (mem_req.addr == {a[31:4], 4'b0000}) else begin
                        errors++;
                        $display("error mem_req.addr: expected %h got %h",
                                 {a[31:4], 4'b0000}, mem_req.addr);
                    end
                end else if (mem_req.req) begin
                    assert (mem_req.addr == first_addr) else begin
                        errors++;
                        $display("error mem_req.addr: expected %h got %h",
                                 first_addr, mem_req.addr);
                    end
                end
                mem_taken = mem_req.req && rd_rdy;
            end
            assert (!addr_ok) else begin
                errors++;
                $display("error addr_ok: expected 0 got %h", addr_ok);
            end
            @(posedge clk);
            #1;
            // Keep a fetch pending while the miss is open
            valid = 1'b1;
            @(negedge clk);
            cnt++;
        end
        if (!data_ok) begin
            $display("timeout: no data_ok for fetch %h", a);
            timeouts++;
            timed_out = 1'b1;
            return;
        end
        assert (rdata == expected_rdata(a)) else begin
            errors++;
            $display("error rdata at %h: expected %h got %h", a, expected_rdata(a), rdata);
        end
        assert (req_seen == vec_miss[i]) else begin
            errors++;
            $display("error mem_req.req at %h: expected %h got %h", a, vec_miss[i], req_seen);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic play_burst(int first, int last);
        bit model_miss;
        bit ok;
        for (int k = first; k <= last; k++) begin
            model_miss = predict_access(vec_addr[k]);
            assert (!model_miss && !vec_miss[k]) else begin
                errors++;
                $display("back to back vector %h is not a predicted hit", vec_addr[k]);
            end
        end
        valid = 1'b1;
        addr = cache_addr_t'(vec_addr[first]);
        wait_accept(vec_addr[first], ok);
        if (!ok) begin
            return;
        end
        for (int k = first + 1; k <= last + 1; k++) begin
            @(posedge clk);
            #1;
            if (k <= last) begin
                addr = cache_addr_t'(vec_addr[k]);
            end else begin
                valid = 1'b0;
            end
            @(negedge clk);
            assert (data_ok) else begin
                errors++;
                $display("error data_ok at %h: expected 1 got %h", vec_addr[k-1], data_ok);
            end
            assert (rdata == expected_rdata(vec_addr[k-1])) else begin
                errors++;
                $display("error rdata at %h: expected %h got %h", vec_addr[k-1],
                         expected_rdata(vec_addr[k-1]), rdata);
            end
            assert (!mem_req.req) else begin
                errors++;
                $display("error mem_req.req: expected 0 got %h", mem_req.req);
            end
            if (k <= last) begin
                assert (addr_ok) else begin
                    errors++;
                    $display("error addr_ok at %h: expected 1 got %h", vec_addr[k], addr_ok);
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    // Line reads with a random rd_rdy delay, data two cycles after acceptance
    initial begin : memory_model
        int          delay;
        logic [31:0] line_addr;
        rd_rdy = 1'b0;
        mem_ret = '0;
        seed = 98747;
        forever begin
            @(posedge clk);
            #1;
            if (resetn && mem_req.req) begin
                delay = $unsigned($random(seed)) % 4;
                line_addr = mem_req.addr;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                rd_rdy = 1'b1;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                @(posedge clk);
                #1;
                mem_ret.valid = 1'b1;
                mem_ret.data = line_for(line_addr);
                @(posedge clk);
                #1;
                mem_ret = '0;
            end
        end
    end

    initial begin : main_flow
        int i;
        int j;
        resetn = 1'b0;
        valid = 1'b0;
        addr = '0;
        errors = 0;
        timeouts = 0;
        timed_out = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_mru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        assert (!mem_req.req) else begin
            errors++;
            $display("error mem_req.req after reset: expected 0 got %h", mem_req.req);
        end
        assert (!addr_ok) else begin
            errors++;
            $display("error addr_ok after reset: expected 0 got %h", addr_ok);
        end
        assert (!data_ok) else begin
            errors++;
            $display("error data_ok after reset: expected 0 got %h", data_ok);
        end
        @(posedge clk);
        #1;
        i = 0;
        while (i < vec_addr.size() && !timed_out) begin
            if (vec_burst[i]) begin
                j = i;
                while (j + 1 < vec_addr.size() && vec_burst[j + 1]) begin
                    j++;
                end
                play_burst(i, j);
                i = j + 1;
            end else begin
                play_one(i);
                i++;
            end
        end
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0 && vec_addr.size() > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/icache_vectors.txt
# address (hex), expected miss (1) or hit (0), back to back (1) or single fetch (0)
# back to back entries are played one per cycle and must all hit
00001000 1 0
00001004 0 0
00001008 0 0
0000100C 0 0
00002010 1 0
0000201C 0 0
FFFFF0F8 1 0
FFFFF0F4 0 0
00001000 0 1
00002014 0 1
0000100C 0 1
FFFFF0F0 0 1
00001004 0 1
000A1050 1 0
000A2054 1 0
000A3058 1 0
000A405C 1 0
000A5050 1 0
000A2050 0 0
000A1054 1 0
000A3058 1 0
000A405C 0 0
000A5050 1 0
000A2054 1 0
000A1058 0 0
000A4050 0 0
000A305C 1 0
000A5054 0 0

// File: flist.f
src/cache_geom_pkg.sv
src/mem_bus_pkg.sv
src/way_ram.sv
src/valid_array.sv
src/plru_table.sv
src/hit_select.sv
src/cache_ctrl.sv
src/icache.sv
test/tb_icache.sv

// File: Makefile
SIM    ?= verilator
TOP    ?= tb_icache
FLIST  ?= flist.f
OBJDIR ?= obj_dir
LOG    ?= sim.log
PASS   ?= Done: no errors
VFLAGS ?= --binary --assert -Wno-fatal

SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FLIST) $(SOURCES) test/icache_vectors.txt
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
